/* hdl/vdma_pkg.sv */
// video DMA write path shared definitions
// pixel and memory word widths, address and burst length types,
// the burst request passed from scheduler to engine

package vdma_pkg;

    // pixel side
    localparam int PIXEL_W = 16;

    // memory side, four pixels per word
    localparam int WORD_W = 64;
    localparam int LANES = WORD_W / PIXEL_W;
    localparam int WORD_BYTES = WORD_W / 8;

    // AXI address and burst length field
    localparam int ADDR_W = 32;
    localparam int LEN_W = 8;

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // words minus one, AXI awlen encoding
    typedef logic [LEN_W-1:0] len_t;

    // one burst to be written
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } burst_req_t;

    // write engine phases
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ADDR = 2'd1,
        ST_DATA = 2'd2,
        ST_RESP = 2'd3
    } wr_state_t;

endpackage

/* hdl/pixel_packer.sv */
// pixel packer
// collects four pixels per memory word, lane 0 in the low bits,
// flushes a zero padded partial word at each new frame

module pixel_packer import vdma_pkg::*; (
    input  logic   clock,
    input  logic   rst,
    input  logic   vsync,
    input  logic   de,
    input  pixel_t idata,
    output logic   word_wr,
    output word_t  word_data,
    output logic   frame_start
);

    localparam int LANE_W = $clog2(LANES);
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(LANES - 1);

    logic [LANE_W-1:0] lane;
    word_t             shreg;
    logic              vsync_d;
    logic              vs_rise;
    logic              rise_d;

    // frame edge, vsync low last cycle and high now
    assign vs_rise = vsync && !vsync_d;

    always_ff @(posedge clock) begin
        if (rst) begin
            vsync_d     <= 1'b0;
            rise_d      <= 1'b0;
            frame_start <= 1'b0;
            word_wr     <= 1'b0;
            lane        <= '0;
        end else begin
            vsync_d <= vsync;
            // flush slot is the cycle after the edge, pulse one later
            rise_d      <= vs_rise;
            frame_start <= rise_d;
            // partial word at the edge, or a completed word
            word_wr <= (vs_rise && lane != '0) || (de && !vs_rise && lane == LAST_LANE);
            if (de) begin
                // pixel on the edge cycle opens the new frame
                lane <= vs_rise ? LANE_W'(1) : lane + 1'b1;
            end else if (vs_rise) begin
                lane <= '0;
            end
        end
    end

    // pixels enter at the top and walk down toward lane 0
    always_ff @(posedge clock) begin
        if (de) begin
            shreg <= {idata, shreg[WORD_W-1:PIXEL_W]};
        end
        if (vs_rise) begin
            // move the filled lanes down, zeros fill the rest
            word_data <= shreg >> ((LANES - int'(lane)) * PIXEL_W);
        end else if (de && lane == LAST_LANE) begin
            word_data <= {idata, shreg[WORD_W-1:PIXEL_W]};
        end
    end

endmodule

/* hdl/word_fifo.sv */
// word FIFO
// synchronous first-word-fall-through buffer between packer and AXI,
// keeps a fill count for the almost full flag

module word_fifo import vdma_pkg::*; #(
    parameter int FIFO_DEPTH = 32,
    parameter int ALMOST_FULL_MARGIN = 4
) (
    input  logic  clock,
    input  logic  rst,
    input  logic  wr_en,
    input  word_t wr_data,
    input  logic  rd_en,
    output word_t rd_data,
    output logic  empty,
    output logic  almost_full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] AF_LEVEL = (PTR_W + 1)'(FIFO_DEPTH - ALMOST_FULL_MARGIN);
    localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W + 1)'(FIFO_DEPTH);

    word_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign full  = (count == FULL_LEVEL);
    assign empty = (count == '0);

    // writes into a full buffer are dropped
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // head word always visible
    assign rd_data = mem[rd_ptr];

    // source is expected to pause here
    assign almost_full = (count >= AF_LEVEL);

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(wr_ok) - (PTR_W + 1)'(rd_ok);
        end
    end

    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* hdl/burst_scheduler.sv */
// burst scheduler
// counts words not yet claimed by a burst, issues full bursts,
// and a tail burst plus base address reload at each frame start

module burst_scheduler import vdma_pkg::*; #(
    parameter int BURST_LEN = 8
) (
    input  logic       clock,
    input  logic       rst,
    input  logic       enable,
    input  addr_t      base_addr,
    input  logic       word_wr,
    input  logic       frame_start,
    input  logic       busy,
    output logic       req_valid,
    output burst_req_t burst_req
);

    // one extra bit so a count of 256 still fits
    localparam int CNT_W = LEN_W + 1;
    localparam logic [CNT_W-1:0] FULL_WORDS = CNT_W'(BURST_LEN);

    logic [CNT_W-1:0] unclaimed;
    logic [CNT_W-1:0] tail_words;
    logic [CNT_W-1:0] issue_words;
    logic             tail_pending;
    addr_t            base_latched;
    addr_t            cur_addr;
    logic             decide;
    logic             issue;
    logic             reload;

    always_comb begin
        // busy is not yet up in the cycle after a strobe
        decide      = enable && !busy && !req_valid && !frame_start;
        issue       = 1'b0;
        reload      = 1'b0;
        issue_words = '0;
        if (decide) begin
            if (tail_pending) begin
                // old frame leftovers first, then jump to the new base
                reload = 1'b1;
                if (tail_words != '0) begin
                    issue       = 1'b1;
                    issue_words = tail_words;
                end
            end else if (unclaimed >= FULL_WORDS) begin
                issue       = 1'b1;
                issue_words = FULL_WORDS;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            unclaimed    <= '0;
            tail_words   <= '0;
            tail_pending <= 1'b0;
            base_latched <= '0;
            cur_addr     <= '0;
            req_valid    <= 1'b0;
        end else begin
            unclaimed <= unclaimed + CNT_W'(word_wr) - issue_words;
            req_valid <= issue;
            if (frame_start) begin
                // all old frame words are counted by now
                tail_pending <= 1'b1;
                tail_words   <= unclaimed;
                base_latched <= base_addr;
            end else if (reload) begin
                tail_pending <= 1'b0;
            end
            if (reload) begin
                cur_addr <= base_latched;
            end else if (issue) begin
                cur_addr <= cur_addr + addr_t'(issue_words) * addr_t'(WORD_BYTES);
            end
        end
    end

    // request payload, sampled by the engine on req_valid
    always_ff @(posedge clock) begin
        if (issue) begin
            burst_req.addr <= cur_addr;
            burst_req.len  <= len_t'(issue_words - 1'b1);
        end
    end

endmodule

/* hdl/axi_write_engine.sv */
// AXI write engine
// runs address, data and response phases for one burst at a time,
// data beats come straight from the FIFO head

module axi_write_engine import vdma_pkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  logic       req_valid,
    input  burst_req_t burst_req,
    input  logic       fifo_empty,
    input  word_t      fifo_data,
    input  logic       axi_awready,
    input  logic       axi_wready,
    input  logic       axi_bvalid,
    output logic       busy,
    output logic       rd_en,
    output logic       axi_awvalid,
    output addr_t      axi_awaddr,
    output len_t       axi_awlen,
    output logic       axi_wvalid,
    output word_t      axi_wdata,
    output logic       axi_wlast,
    output logic       axi_bready
);

    wr_state_t  state;
    burst_req_t req_q;
    len_t       beat_cnt;
    logic       last_beat;
    logic       beat;

    // held from the cycle after the request until after B
    assign busy = (state != ST_IDLE);

    // address phase
    assign axi_awvalid = (state == ST_ADDR);
    assign axi_awaddr  = req_q.addr;
    assign axi_awlen   = req_q.len;

    // data phase, valid follows the FIFO
    assign last_beat  = (beat_cnt == req_q.len);
    assign axi_wvalid = (state == ST_DATA) && !fifo_empty;
    assign axi_wdata  = fifo_data;
    assign axi_wlast  = (state == ST_DATA) && last_beat;
    assign beat       = axi_wvalid && axi_wready;

    // pop the head on each accepted beat
    assign rd_en = beat;

    // response phase
    assign axi_bready = (state == ST_RESP);

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (axi_awready) begin
                        state    <= ST_DATA;
                        beat_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    if (beat) begin
                        if (last_beat) begin
                            state <= ST_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                ST_RESP: begin
                    // response code is not looked at
                    if (axi_bvalid) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request is only sampled while idle
    always_ff @(posedge clock) begin
        if (state == ST_IDLE && req_valid) begin
            req_q <= burst_req;
        end
    end

endmodule

/* hdl/vdma_write_top.sv */
// video to memory write channel
// packs native video into 64-bit words, buffers them in a FIFO
// and writes them out as AXI bursts, one burst in flight

module vdma_write_top import vdma_pkg::*; #(
    parameter int BURST_LEN = 8,
    parameter int FIFO_DEPTH = 32,
    parameter int ALMOST_FULL_MARGIN = 4
) (
    input  logic   clock,
    input  logic   rst,
    input  logic   enable,
    input  addr_t  base_addr,
    input  logic   vsync,
    input  logic   de,
    input  pixel_t idata,
    output logic   fifo_almost_full,
    output logic   axi_awvalid,
    input  logic   axi_awready,
    output addr_t  axi_awaddr,
    output len_t   axi_awlen,
    output logic   axi_wvalid,
    input  logic   axi_wready,
    output word_t  axi_wdata,
    output logic   axi_wlast,
    output logic   axi_bready,
    input  logic   axi_bvalid
);

    // packer outputs
    logic       word_wr;
    word_t      word_data;
    logic       frame_start;

    // FIFO read side
    logic       fifo_rd_en;
    word_t      fifo_rd_data;
    logic       fifo_empty;

    // scheduler to engine
    logic       req_valid;
    burst_req_t burst_req;
    logic       busy;

    pixel_packer pixel_packer_inst (
        .clock       (clock),
        .rst         (rst),
        .vsync       (vsync),
        .de          (de),
        .idata       (idata),
        .word_wr     (word_wr),
        .word_data   (word_data),
        .frame_start (frame_start)
    );

    word_fifo #(
        .FIFO_DEPTH         (FIFO_DEPTH),
        .ALMOST_FULL_MARGIN (ALMOST_FULL_MARGIN)
    ) word_fifo_inst (
        .clock       (clock),
        .rst         (rst),
        .wr_en       (word_wr),
        .wr_data     (word_data),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty),
        .almost_full (fifo_almost_full)
    );

    // counts the packer strobes itself
    burst_scheduler #(
        .BURST_LEN (BURST_LEN)
    ) burst_scheduler_inst (
        .clock       (clock),
        .rst         (rst),
        .enable      (enable),
        .base_addr   (base_addr),
        .word_wr     (word_wr),
        .frame_start (frame_start),
        .busy        (busy),
        .req_valid   (req_valid),
        .burst_req   (burst_req)
    );

    axi_write_engine axi_write_engine_inst (
        .clock       (clock),
        .rst         (rst),
        .req_valid   (req_valid),
        .burst_req   (burst_req),
        .fifo_empty  (fifo_empty),
        .fifo_data   (fifo_rd_data),
        .axi_awready (axi_awready),
        .axi_wready  (axi_wready),
        .axi_bvalid  (axi_bvalid),
        .busy        (busy),
        .rd_en       (fifo_rd_en),
        .axi_awvalid (axi_awvalid),
        .axi_awaddr  (axi_awaddr),
        .axi_awlen   (axi_awlen),
        .axi_wvalid  (axi_wvalid),
        .axi_wdata   (axi_wdata),
        .axi_wlast   (axi_wlast),
        .axi_bready  (axi_bready)
    );

endmodule

/* testbench/tb_vdma_write.sv */
// testbench for the video DMA write channel
// drives pixels and frame edges, models packing and burst scheduling,
// answers AXI with random ready and response delays

module tb_vdma_write import vdma_pkg::*; ();

    localparam int BURST_LEN = 8;
    localparam int FIFO_DEPTH = 32;
    localparam int ALMOST_FULL_MARGIN = 4;
    localparam int STALL_LIMIT = 2000;
    localparam int DRAIN_LIMIT = 5000;

    logic   clock = 1'b0;
    logic   rst;
    logic   enable;
    addr_t  base_addr;
    logic   vsync;
    logic   de;
    pixel_t idata;
    logic   fifo_almost_full;
    logic   axi_awvalid;
    logic   axi_awready = 1'b0;
    addr_t  axi_awaddr;
    len_t   axi_awlen;
    logic   axi_wvalid;
    logic   axi_wready = 1'b0;
    word_t  axi_wdata;
    logic   axi_wlast;
    logic   axi_bready;
    logic   axi_bvalid = 1'b0;

    // expected words and bursts
    word_t      exp_words[$];
    burst_req_t exp_bursts[$];
    int         exp_total = 0;
    word_t      model_word = '0;
    int         model_lane = 0;
    int         unclaimed = 0;
    addr_t      model_addr = '0;
    int         px_count = 0;

    // bus monitor state
    int         b_count = 0;
    logic       outstanding = 1'b0;
    logic       in_data = 1'b0;
    logic       resp_owed = 1'b0;
    logic       hold_check = 1'b0;
    len_t       cur_len = '0;
    int         beat_idx = 0;
    burst_req_t exp_req;
    word_t      exp_word;

    logic [15:0] lfsr = 16'd45683;

    always #2 clock = ~clock;

    vdma_write_top #(
        .BURST_LEN          (BURST_LEN),
        .FIFO_DEPTH         (FIFO_DEPTH),
        .ALMOST_FULL_MARGIN (ALMOST_FULL_MARGIN)
    ) vdma_write_top_inst (
        .clock            (clock),
        .rst              (rst),
        .enable           (enable),
        .base_addr        (base_addr),
        .vsync            (vsync),
        .de               (de),
        .idata            (idata),
        .fifo_almost_full (fifo_almost_full),
        .axi_awvalid      (axi_awvalid),
        .axi_awready      (axi_awready),
        .axi_awaddr       (axi_awaddr),
        .axi_awlen        (axi_awlen),
        .axi_wvalid       (axi_wvalid),
        .axi_wready       (axi_wready),
        .axi_wdata        (axi_wdata),
        .axi_wlast        (axi_wlast),
        .axi_bready       (axi_bready),
        .axi_bvalid       (axi_bvalid)
    );

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
        stop_run();
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    // galois step, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    // ready about three cycles in four
    function automatic logic ready_draw();
        logic b0;
        logic b1;
        b0 = take_bit();
        b1 = take_bit();
        return b0 | b1;
    endfunction

    task automatic push_burst(input addr_t addr, input int words);
        burst_req_t req;
        req.addr = addr;
        req.len  = len_t'(words - 1);
        exp_bursts.push_back(req);
        exp_total++;
    endtask

    // lane 0 takes the first pixel of a word
    task automatic pack_pixel(input pixel_t p);
        model_word[model_lane*PIXEL_W +: PIXEL_W] = p;
        model_lane++;
        if (model_lane == LANES) begin
            exp_words.push_back(model_word);
            model_word = '0;
            model_lane = 0;
            unclaimed++;
            if (unclaimed == BURST_LEN) begin
                push_burst(model_addr, BURST_LEN);
                model_addr = model_addr + addr_t'(BURST_LEN * WORD_BYTES);
                unclaimed  = 0;
            end
        end
    endtask

    // zero padded flush, tail burst, then jump to the new base
    task automatic close_frame();
        if (model_lane != 0) begin
            exp_words.push_back(model_word);
            model_word = '0;
            model_lane = 0;
            unclaimed++;
        end
        if (unclaimed > 0) begin
            push_burst(model_addr, unclaimed);
        end
        model_addr = base_addr;
        unclaimed  = 0;
    endtask

    // one pixel per cycle, pausing while the FIFO is almost full
    task automatic send_pixels(input int n);
        int     stall;
        pixel_t p;
        for (int i = 0; i < n; i++) begin
            @(negedge clock);
            stall = 0;
            while (fifo_almost_full) begin
                de = 1'b0;
                stall++;
                if (stall > STALL_LIMIT) begin
                    report_error("FIFO stayed almost full, pixel source stalled too long");
                end
                @(negedge clock);
            end
            p = 16'h8000 | 16'(px_count);
            px_count++;
            de    = 1'b1;
            idata = p;
            pack_pixel(p);
        end
        @(negedge clock);
        de = 1'b0;
    endtask

    task automatic frame_edge();
        @(negedge clock);
        vsync = 1'b1;
        close_frame();
        @(negedge clock);
        @(negedge clock);
        vsync = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (b_count != exp_total || outstanding) begin
            @(negedge clock);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                report_error("expected bursts did not complete before the timeout");
            end
        end
    endtask

    // no address phase while bursts are held back
    assert property (@(posedge clock) disable iff (rst) !(hold_check && axi_awvalid))
        else report_mismatch("axi_awvalid", 64'(axi_awvalid), 64'd0);

    // slave side, driven on the falling edge
    always @(negedge clock) begin
        if (rst) begin
            axi_awready = 1'b0;
            axi_wready  = 1'b0;
            axi_bvalid  = 1'b0;
        end else begin
            axi_awready = ready_draw();
            axi_wready  = ready_draw();
            if (axi_bvalid && !resp_owed) begin
                axi_bvalid = 1'b0;
            end
            if (!axi_bvalid && resp_owed) begin
                axi_bvalid = take_bit();
            end
        end
    end

    // handshake checks against the model
    always @(posedge clock) begin
        if (!rst) begin
            if (axi_awvalid && axi_awready) begin
                assert (!outstanding)
                    else report_error("address handshake before previous response");
                assert (exp_bursts.size() > 0)
                    else report_error("address handshake with no burst expected");
                exp_req = exp_bursts.pop_front();
                assert (axi_awaddr == exp_req.addr)
                    else report_mismatch("axi_awaddr", 64'(axi_awaddr), 64'(exp_req.addr));
                assert (axi_awlen == exp_req.len)
                    else report_mismatch("axi_awlen", 64'(axi_awlen), 64'(exp_req.len));
                cur_len     = exp_req.len;
                beat_idx    = 0;
                outstanding = 1'b1;
                in_data     = 1'b1;
            end
            if (axi_wvalid && axi_wready) begin
                assert (in_data) else report_error("data beat outside a burst");
                assert (exp_words.size() > 0) else report_error("data beat with no word expected");
                exp_word = exp_words.pop_front();
                assert (axi_wdata == exp_word)
                    else report_mismatch("axi_wdata", axi_wdata, exp_word);
                assert (axi_wlast == (beat_idx == int'(cur_len)))
                    else report_mismatch("axi_wlast", 64'(axi_wlast),
                                         64'(beat_idx == int'(cur_len)));
                if (beat_idx == int'(cur_len)) begin
                    in_data   = 1'b0;
                    resp_owed = 1'b1;
                end
                beat_idx++;
            end
            if (axi_bvalid && axi_bready) begin
                outstanding = 1'b0;
                resp_owed   = 1'b0;
                b_count++;
            end
        end
    end

    initial begin
        rst       = 1'b1;
        enable    = 1'b0;
        base_addr = '0;
        vsync     = 1'b0;
        de        = 1'b0;
        idata     = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst       = 1'b0;
        enable    = 1'b1;
        base_addr = 32'h1000_0000;
        @(negedge clock);
        assert (!axi_awvalid && !axi_wvalid && !axi_bready && !fifo_almost_full)
            else report_error("AXI valid or almost full high after reset");

        // words ahead of the first frame edge land at address zero
        send_pixels(32);
        wait_drained();
        frame_edge();

        // 37 pixels, full burst then a two word tail
        send_pixels(37);
        wait_drained();
        base_addr = 32'h2000_0000;
        frame_edge();

        // long frame under random back-pressure
        send_pixels(203);
        wait_drained();
        base_addr = 32'h2400_0000;
        frame_edge();
        wait_drained();

        // bursts held while enable is low, FIFO filled up to the almost full level
        enable     = 1'b0;
        hold_check = 1'b1;
        send_pixels((FIFO_DEPTH - ALMOST_FULL_MARGIN) * LANES);
        repeat (30) @(negedge clock);
        assert (fifo_almost_full)
            else report_mismatch("fifo_almost_full", 64'(fifo_almost_full), 64'd1);
        hold_check = 1'b0;
        enable     = 1'b1;
        wait_drained();
        // only the unclaimed leftover words remain stored
        assert (!fifo_almost_full)
            else report_mismatch("fifo_almost_full", 64'(fifo_almost_full), 64'd0);
        send_pixels(18);
        wait_drained();
        base_addr = 32'h3000_0000;
        frame_edge();
        wait_drained();

        assert (exp_words.size() == 0) else report_error("expected words never written");
        assert (exp_bursts.size() == 0) else report_error("expected bursts never issued");
        $display("test passed");
        $finish;
    end

endmodule

/* vdma_write.f */
hdl/vdma_pkg.sv
hdl/pixel_packer.sv
hdl/word_fifo.sv
hdl/burst_scheduler.sv
hdl/axi_write_engine.sv
hdl/vdma_write_top.sv
testbench/tb_vdma_write.sv

/* run_sim.sh */
#!/bin/sh
# build and run the video DMA write channel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vdma_write.f \
    --top-module tb_vdma_write -o tb_vdma_write

./obj_dir/tb_vdma_write 2>&1 | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
